/* design/neuron_pkg.sv */
package neuron_pkg;

    // signed Q8.8 with one sign bit on top
    localparam int N_INT  = 8;
    localparam int N_MANT = 8;

    typedef logic signed [N_INT+N_MANT:0] fix_t;

    localparam fix_t FIX_MAX = {1'b0, {(N_INT + N_MANT){1'b1}}};
    localparam fix_t FIX_MIN = {1'b1, {(N_INT + N_MANT){1'b0}}};

    typedef enum logic {
        FIX_ADD,
        FIX_SUB
    } fix_op_t;

    // index 15 first, every magnitude below 32.0
    // the plain sum is above 256.0, so all ones or all zeros saturates the tree
    localparam fix_t [15:0] DEFAULT_WEIGHTS = '{
        17'sh01080, 17'sh015C0, 17'sh01C00, -17'sh00680,
        17'sh01800, 17'sh00E40, 17'sh01F80, 17'sh01300,
        -17'sh00800, 17'sh01BC0, 17'sh00C80, 17'sh01600,
        17'sh01E00, -17'sh003C0, 17'sh01240, 17'sh01980
    };

    // -2.5
    localparam fix_t DEFAULT_BIAS = -17'sh00280;

endpackage

/* design/chunk_collector.sv */
`timescale 1ns/1ps

module chunk_collector #(
    parameter int N_IN  = 16,
    parameter int CHUNK = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  logic [CHUNK-1:0] in_bits,
    input  logic             restart,
    output logic [N_IN-1:0]  sel_vec,
    output logic             vec_valid
);

    localparam int NUM_CHUNKS = N_IN / CHUNK;
    localparam int CNT_W      = (NUM_CHUNKS > 1) ? $clog2(NUM_CHUNKS) : 1;
    localparam logic [CNT_W-1:0] LAST_CHUNK = CNT_W'(NUM_CHUNKS - 1);

    logic [CNT_W-1:0] chunk_cnt;
    logic [N_IN-1:0]  shift_q;
    logic [N_IN-1:0]  shift_next;
    logic             take;

    // newest chunk enters at the top, so chunk 0 lands in the low bits
    assign shift_next = {in_bits, shift_q[N_IN-1:CHUNK]};
    assign take       = in_valid && !restart;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            chunk_cnt <= '0;
            vec_valid <= 1'b0;
            sel_vec   <= '0;
        end else begin
            vec_valid <= 1'b0;
            if (restart) begin
                // drop whatever was collected so far
                chunk_cnt <= '0;
            end else if (in_valid) begin
                if (chunk_cnt == LAST_CHUNK) begin
                    chunk_cnt <= '0;
                    sel_vec   <= shift_next;
                    vec_valid <= 1'b1;
                end else begin
                    chunk_cnt <= chunk_cnt + CNT_W'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            shift_q <= shift_next;
        end
    end

endmodule

/* design/da_lut.sv */
`timescale 1ns/1ps

module da_lut #(
    parameter int SIZE = 4,
    parameter neuron_pkg::fix_t [SIZE-1:0] WEIGHTS_SLICE = '0
) (
    input  logic [SIZE-1:0]  sel,
    output neuron_pkg::fix_t result
);

    localparam int ENTRIES = 2 ** SIZE;

    typedef neuron_pkg::fix_t [ENTRIES-1:0] table_t;

    // entry e holds the sum of +w for set bits of e and -w for clear bits
    function automatic table_t build_table();
        table_t           tbl;
        neuron_pkg::fix_t acc;
        neuron_pkg::fix_t w;
        for (int e = 0; e < ENTRIES; e++) begin
            acc = '0;
            for (int j = 0; j < SIZE; j++) begin
                w = WEIGHTS_SLICE[j];
                if (e[j]) begin
                    acc = acc + w;
                end else begin
                    acc = acc - w;
                end
            end
            tbl[e] = acc;
        end
        return tbl;
    endfunction

    localparam table_t LUT = build_table();

    assign result = LUT[sel];

endmodule

/* design/fix_pu.sv */
`timescale 1ns/1ps

module fix_pu #(
    parameter neuron_pkg::fix_op_t OP = neuron_pkg::FIX_ADD
) (
    input  logic             clk,
    input  logic             rst_n,
    input  neuron_pkg::fix_t a,
    input  neuron_pkg::fix_t b,
    output neuron_pkg::fix_t result
);

    localparam int W = $bits(neuron_pkg::fix_t);

    logic signed [W:0] a_ext;
    logic signed [W:0] b_ext;
    logic signed [W:0] wide;
    neuron_pkg::fix_t  sat;

    // one guard bit is enough for a single add or subtract
    assign a_ext = {a[W-1], a};
    assign b_ext = {b[W-1], b};
    assign wide  = (OP == neuron_pkg::FIX_SUB) ? (a_ext - b_ext) : (a_ext + b_ext);

    // guard and sign bit disagree on overflow
    always_comb begin
        if (wide[W] != wide[W-1]) begin
            sat = wide[W] ? neuron_pkg::FIX_MIN : neuron_pkg::FIX_MAX;
        end else begin
            sat = wide[W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result <= '0;
        end else begin
            result <= sat;
        end
    end

endmodule

/* design/da_lut_unit.sv */
`timescale 1ns/1ps

module da_lut_unit #(
    parameter int N_IN     = 16,
    parameter int LUT_SIZE = 4,
    parameter neuron_pkg::fix_t [N_IN-1:0] WEIGHTS = '0
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [N_IN-1:0]  sel_vec,
    output neuron_pkg::fix_t tree_sum
);

    localparam int NUM_LUTS = (N_IN + LUT_SIZE - 1) / LUT_SIZE;
    localparam int LAYERS   = $clog2(NUM_LUTS);

    // number of live nodes in a tree layer, layer 0 being the tables
    function automatic int layer_width(input int l);
        int w;
        w = NUM_LUTS;
        for (int s = 0; s < l; s++) begin
            w = (w + 1) / 2;
        end
        return w;
    endfunction

    // node[0] are the table outputs, node[LAYERS][0] is the root
    neuron_pkg::fix_t node [LAYERS+1][NUM_LUTS];

    for (genvar i = 0; i < NUM_LUTS; i++) begin : g_lut
        localparam int OFFSET = i * LUT_SIZE;
        // last table is shorter when N_IN is not a multiple of LUT_SIZE
        localparam int LUT_W  = (N_IN - OFFSET < LUT_SIZE) ? (N_IN - OFFSET) : LUT_SIZE;
        localparam neuron_pkg::fix_t [LUT_W-1:0] SLICE = WEIGHTS[OFFSET +: LUT_W];

        da_lut #(
            .SIZE          (LUT_W),
            .WEIGHTS_SLICE (SLICE)
        ) u_lut (
            .sel    (sel_vec[OFFSET +: LUT_W]),
            .result (node[0][i])
        );
    end

    for (genvar l = 0; l < LAYERS; l++) begin : g_layer
        localparam int W_IN  = layer_width(l);
        localparam int W_OUT = layer_width(l + 1);

        for (genvar k = 0; k < NUM_LUTS; k++) begin : g_node
            neuron_pkg::fix_t node_q;

            if (2 * k + 1 < W_IN) begin : g_add
                fix_pu #(
                    .OP (neuron_pkg::FIX_ADD)
                ) u_add (
                    .clk    (clk),
                    .rst_n  (rst_n),
                    .a      (node[l][2*k]),
                    .b      (node[l][2*k+1]),
                    .result (node_q)
                );
            end else if (k < W_OUT) begin : g_pass
                // odd leftover takes the same one cycle as an adder
                always_ff @(posedge clk) begin
                    if (!rst_n) begin
                        node_q <= '0;
                    end else begin
                        node_q <= node[l][2*k];
                    end
                end
            end else begin : g_idle
                // slots past the layer width
                assign node_q = '0;
            end

            assign node[l+1][k] = node_q;
        end
    end

    assign tree_sum = node[LAYERS][0];

endmodule

/* design/neuron_output.sv */
`timescale 1ns/1ps

module neuron_output #(
    parameter int TREE_LATENCY = 2,
    parameter neuron_pkg::fix_t BIAS = '0
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             vec_valid,
    input  neuron_pkg::fix_t tree_sum,
    output logic             out_valid,
    output neuron_pkg::fix_t sum,
    output logic             active
);

    // tree stages plus the bias register
    logic [TREE_LATENCY:0] valid_sr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_sr <= '0;
        end else begin
            valid_sr[0] <= vec_valid;
            for (int i = 1; i <= TREE_LATENCY; i++) begin
                valid_sr[i] <= valid_sr[i-1];
            end
        end
    end

    assign out_valid = valid_sr[TREE_LATENCY];

    fix_pu #(
        .OP (neuron_pkg::FIX_ADD)
    ) u_bias (
        .clk    (clk),
        .rst_n  (rst_n),
        .a      (tree_sum),
        .b      (BIAS),
        .result (sum)
    );

    // zero counts as active
    assign active = ~sum[$bits(neuron_pkg::fix_t)-1];

endmodule

/* design/bnn_neuron_top.sv */
`timescale 1ns/1ps

module bnn_neuron_top #(
    parameter int N_IN     = 16,
    parameter int LUT_SIZE = 4,
    parameter int CHUNK    = 4,
    parameter neuron_pkg::fix_t [N_IN-1:0] WEIGHTS = neuron_pkg::DEFAULT_WEIGHTS,
    parameter neuron_pkg::fix_t BIAS = neuron_pkg::DEFAULT_BIAS
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  logic [CHUNK-1:0] in_bits,
    input  logic             restart,
    output logic             out_valid,
    output neuron_pkg::fix_t sum,
    output logic             active
);

    localparam int TREE_LATENCY = $clog2((N_IN + LUT_SIZE - 1) / LUT_SIZE);

    logic [N_IN-1:0]  sel_vec;
    logic             vec_valid;
    neuron_pkg::fix_t tree_sum;

    chunk_collector #(
        .N_IN  (N_IN),
        .CHUNK (CHUNK)
    ) u_collector (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_bits   (in_bits),
        .restart   (restart),
        .sel_vec   (sel_vec),
        .vec_valid (vec_valid)
    );

    da_lut_unit #(
        .N_IN     (N_IN),
        .LUT_SIZE (LUT_SIZE),
        .WEIGHTS  (WEIGHTS)
    ) u_lut_unit (
        .clk      (clk),
        .rst_n    (rst_n),
        .sel_vec  (sel_vec),
        .tree_sum (tree_sum)
    );

    neuron_output #(
        .TREE_LATENCY (TREE_LATENCY),
        .BIAS         (BIAS)
    ) u_output (
        .clk       (clk),
        .rst_n     (rst_n),
        .vec_valid (vec_valid),
        .tree_sum  (tree_sum),
        .out_valid (out_valid),
        .sum       (sum),
        .active    (active)
    );

endmodule

/* testbench/tb_bnn_neuron.sv */
`timescale 1ns/1ps

module tb_bnn_neuron;

    localparam int N_IN        = 16;
    localparam int LUT_SIZE    = 4;
    localparam int CHUNK       = 4;
    localparam int NUM_CHUNKS  = N_IN / CHUNK;
    // from the edge that samples the last chunk: two tree stages and the bias register
    localparam int OUT_LATENCY = 3;
    localparam int DRAIN_LIMIT = 40;
    localparam int NUM_RANDOM  = 60;

    logic             clk;
    logic             rst_n;
    logic             in_valid;
    logic [CHUNK-1:0] in_bits;
    logic             restart;
    logic             out_valid;
    neuron_pkg::fix_t sum;
    logic             active;

    logic [31:0]     rng_state;
    int              edge_cnt;
    int              chunk_idx;
    logic [N_IN-1:0] model_vec;
    int              exp_sum [$];
    int              exp_edge [$];
    int              vectors_done;
    int              results_seen;
    int              value_errs;
    int              timing_errs;
    int              other_errs;

    bnn_neuron_top #(
        .N_IN     (N_IN),
        .LUT_SIZE (LUT_SIZE),
        .CHUNK    (CHUNK),
        .WEIGHTS  (neuron_pkg::DEFAULT_WEIGHTS),
        .BIAS     (neuron_pkg::DEFAULT_BIAS)
    ) DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_bits   (in_bits),
        .restart   (restart),
        .out_valid (out_valid),
        .sum       (sum),
        .active    (active)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return {16'h0, rng_state[31:16]};
    endfunction

    function automatic logic [CHUNK-1:0] rand_chunk();
        logic [31:0] r;
        r = lcg_next();
        return r[CHUNK-1:0];
    endfunction

    function automatic int saturate(input int x);
        int hi;
        int lo;
        hi = int'(neuron_pkg::FIX_MAX);
        lo = int'(neuron_pkg::FIX_MIN);
        if (x > hi) begin
            return hi;
        end
        if (x < lo) begin
            return lo;
        end
        return x;
    endfunction

    function automatic int weight_of(input logic [3:0] idx);
        neuron_pkg::fix_t w;
        w = neuron_pkg::DEFAULT_WEIGHTS[idx];
        return int'(w);
    endfunction

    // +w for a set bit, -w for a clear bit, never clamped
    function automatic int table_sum(input logic [N_IN-1:0] vec, input int base);
        int         acc;
        logic [3:0] bit_idx;
        acc = 0;
        for (int j = 0; j < LUT_SIZE; j++) begin
            bit_idx = 4'(base + j);
            if (vec[bit_idx]) begin
                acc = acc + weight_of(bit_idx);
            end else begin
                acc = acc - weight_of(bit_idx);
            end
        end
        return acc;
    endfunction

    function automatic int model_sum(input logic [N_IN-1:0] vec);
        int pair0;
        int pair1;
        int root;
        pair0 = saturate(table_sum(vec, 0) + table_sum(vec, 4));
        pair1 = saturate(table_sum(vec, 8) + table_sum(vec, 12));
        root  = saturate(pair0 + pair1);
        return saturate(root + int'(neuron_pkg::DEFAULT_BIAS));
    endfunction

    // called on a falling edge, returns on a falling edge
    task automatic send_chunk(input logic [CHUNK-1:0] bits, input int gap);
        in_valid = 1'b1;
        in_bits  = bits;
        model_vec[4'(chunk_idx * CHUNK) +: CHUNK] = bits;
        chunk_idx = chunk_idx + 1;
        if (chunk_idx == NUM_CHUNKS) begin
            exp_sum.push_back(model_sum(model_vec));
            // the coming rising edge samples this chunk
            exp_edge.push_back(edge_cnt + 1 + OUT_LATENCY);
            vectors_done = vectors_done + 1;
            chunk_idx = 0;
        end
        @(negedge clk);
        in_valid = 1'b0;
        in_bits  = '0;
        repeat (gap) @(negedge clk);
    endtask

    task automatic pulse_restart(input logic with_chunk);
        restart  = 1'b1;
        // a chunk on the restart edge is dropped too
        in_valid = with_chunk;
        in_bits  = rand_chunk();
        chunk_idx = 0;
        @(negedge clk);
        restart  = 1'b0;
        in_valid = 1'b0;
    endtask

    always @(negedge clk) begin
        int   exp_val;
        int   exp_at;
        logic exp_act;
        if (rst_n && !out_valid && exp_edge.size() != 0) begin
            if (edge_cnt >= exp_edge[0]) begin
                $display("Error: time %0t out_valid expected 1 got 0 at edge %0d",
                         $time, exp_edge[0]);
                timing_errs = timing_errs + 1;
                exp_val = exp_sum.pop_front();
                exp_at  = exp_edge.pop_front();
            end
        end
        if (rst_n && out_valid) begin
            results_seen = results_seen + 1;
            if (exp_sum.size() == 0) begin
                $display("Error: out_valid pulsed at time %0t with no vector outstanding", $time);
                other_errs = other_errs + 1;
            end else begin
                exp_val = exp_sum.pop_front();
                exp_at  = exp_edge.pop_front();
                exp_act = (exp_val >= 0);
                if (int'(sum) != exp_val) begin
                    $display("Error: time %0t sum expected %0d got %0d",
                             $time, exp_val, int'(sum));
                    value_errs = value_errs + 1;
                end
                if (active != exp_act) begin
                    $display("Error: time %0t active expected %b got %b",
                             $time, exp_act, active);
                    value_errs = value_errs + 1;
                end
                if (edge_cnt != exp_at) begin
                    $display("Error: time %0t out_valid edge expected %0d got %0d",
                             $time, exp_at, edge_cnt);
                    timing_errs = timing_errs + 1;
                end
            end
        end
    end

    initial begin
        int          drain;
        logic [31:0] r;
        clk          = 1'b0;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_bits      = '0;
        restart      = 1'b0;
        rng_state    = 32'hf938;
        edge_cnt     = 0;
        chunk_idx    = 0;
        model_vec    = '0;
        vectors_done = 0;
        results_seen = 0;
        value_errs   = 0;
        timing_errs  = 0;
        other_errs   = 0;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // quiet output until the first vector is in
        repeat (6) begin
            @(negedge clk);
            if (out_valid !== 1'b0) begin
                $display("Error: time %0t out_valid expected 0 got %b", $time, out_valid);
                value_errs = value_errs + 1;
            end
        end

        // top and bottom clamp, fed back to back
        repeat (NUM_CHUNKS) send_chunk(4'hf, 0);
        repeat (NUM_CHUNKS) send_chunk(4'h0, 0);
        repeat (3 * NUM_CHUNKS) send_chunk(rand_chunk(), 0);

        // half a vector, then a restart
        send_chunk(rand_chunk(), 1);
        send_chunk(rand_chunk(), 0);
        pulse_restart(1'b1);
        repeat (NUM_CHUNKS) send_chunk(rand_chunk(), 0);

        for (int n = 0; n < NUM_RANDOM * NUM_CHUNKS; n++) begin
            r = lcg_next();
            if (r[7:4] == 4'h0) begin
                pulse_restart(r[8]);
            end
            send_chunk(r[3:0], int'(r[10:9]));
        end

        drain = 0;
        while (exp_sum.size() != 0 && drain < DRAIN_LIMIT) begin
            @(negedge clk);
            drain = drain + 1;
        end
        if (exp_sum.size() != 0) begin
            $display("Error: timed out with %0d results still outstanding", exp_sum.size());
            other_errs = other_errs + 1;
        end
        // room for a stray pulse to show up
        repeat (8) @(negedge clk);

        if (results_seen != vectors_done) begin
            $display("Error: out_valid pulses expected %0d got %0d", vectors_done, results_seen);
            other_errs = other_errs + 1;
        end

        $display("results %0d of %0d vectors, value errors %0d, timing errors %0d, other errors %0d",
                 results_seen, vectors_done, value_errs, timing_errs, other_errs);
        if (value_errs + timing_errs + other_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* project.f */
design/neuron_pkg.sv
design/chunk_collector.sv
design/da_lut.sv
design/fix_pu.sv
design/da_lut_unit.sv
design/neuron_output.sv
design/bnn_neuron_top.sv
testbench/tb_bnn_neuron.sv

/* Makefile */
TOOL       = verilator
FILELIST   = project.f
TB_TOP     = tb_bnn_neuron
RTL_TOP    = bnn_neuron_top
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing -j 0
PASS_MSG   = TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TB_TOP)

# the grep sets the exit status of the run
sim:
	$(TOOL) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TB_TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
